// ==== Makefile ====
TOP = tb_ahb2apb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== build.f ====
verilog/ahb_pkg.sv
verilog/apb_pkg.sv
verilog/apb_slot_if.sv
verilog/ahb_front_end.sv
verilog/apb_slot.sv
verilog/apb_sequencer.sv
verilog/ahb2apb_bridge.sv
dv/tb_ahb2apb.sv

// ==== dv/tb_ahb2apb.sv ====
// Bridge testbench; fixed 4-slave map at 0x1000 steps, fixed seed, needs concurrent assertion support
`timescale 1ns/1ps
`default_nettype none

module tb_ahb2apb;

  localparam int NUM_SLAVES   = 4;
  localparam int NUM_XFERS    = 200;
  localparam int XFER_TIMEOUT = 20;

  logic                            hclk10;
  logic                            hreset_n10;
  logic                            hsel;
  logic                            hwrite;
  logic                            hready;
  logic                            penable;
  logic                            pwrite;
  ahb_pkg::addr_t                  haddr;
  ahb_pkg::addr_t                  paddr;
  ahb_pkg::htrans_t                htrans;
  ahb_pkg::data_t                  hwdata;
  ahb_pkg::data_t                  hrdata;
  ahb_pkg::data_t                  pwdata;
  logic [NUM_SLAVES-1:0]           psel;
  logic [NUM_SLAVES-1:0]           pready = '1;
  ahb_pkg::data_t [NUM_SLAVES-1:0] prdata = '1;

  // Expected contents, and the memories behind the slave models
  ahb_pkg::data_t ref_mem [NUM_SLAVES][64];
  ahb_pkg::data_t slave_mem [NUM_SLAVES][64];
  logic [1:0]     wait_cnt [NUM_SLAVES];
  logic [31:0]    wait_rng;

  logic           accept;
  logic           psel_any;
  logic           stall;
  logic           started;
  logic           acc_d1;
  logic           acc_d2;
  logic           wr_d1;
  logic           wr_d2;
  ahb_pkg::addr_t addr_d1;
  ahb_pkg::addr_t addr_d2;
  logic           check_read;
  logic           chk_rd_q;
  ahb_pkg::data_t exp_rdata;
  ahb_pkg::data_t exp_rd_q;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic apb_pkg::slave_map_t build_map(input logic [31:0] offset);
    apb_pkg::slave_map_t m;
    m = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      m[i] = 32'h1000 * 32'(i + 1) + offset;
    end
    return m;
  endfunction

  // 256-byte windows at 0x1000, 0x2000, 0x3000, 0x4000
  localparam apb_pkg::slave_map_t WIN_BASE = build_map(32'h0);
  localparam apb_pkg::slave_map_t WIN_LAST = build_map(32'hff);

  function automatic logic [NUM_SLAVES-1:0] window_sel(input ahb_pkg::addr_t a);
    logic [NUM_SLAVES-1:0] sel;
    sel = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      sel[i] = (a >= WIN_BASE[i]) && (a <= WIN_LAST[i]);
    end
    return sel;
  endfunction

  function automatic ahb_pkg::data_t fill_word(input ahb_pkg::addr_t a);
    return {a[7:0], a[31:8]} ^ 32'h5a5a_a5a5;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  ahb2apb_bridge #(
    .NUM_SLAVES (NUM_SLAVES),
    .SLAVE_BASE (WIN_BASE),
    .SLAVE_LAST (WIN_LAST)
  ) dut_i (
    .hclk10 (hclk10), .hreset_n10 (hreset_n10), .hsel (hsel), .haddr (haddr),
    .htrans (htrans), .hwdata (hwdata), .hwrite (hwrite), .hrdata (hrdata),
    .hready (hready), .paddr (paddr), .penable (penable), .pwrite (pwrite),
    .pwdata (pwdata), .psel (psel), .pready (pready), .prdata (prdata)
  );

  initial begin
    hclk10 = 1'b0;
    forever #5 hclk10 = ~hclk10;
  end

  // ----------------------------------------
  // Expected-value pipeline
  // ----------------------------------------

  assign accept   = hsel && hready && (htrans == ahb_pkg::HTRANS_NONSEQ ||
                                       htrans == ahb_pkg::HTRANS_SEQ);
  assign psel_any = |psel;
  assign stall    = penable && psel_any && !(|(psel & pready));

  always @(posedge hclk10 or negedge hreset_n10) begin
    if (!hreset_n10) begin
      started  <= 1'b0;
      acc_d1   <= 1'b0;
      acc_d2   <= 1'b0;
      addr_d1  <= '0;
      addr_d2  <= '0;
      wr_d1    <= 1'b0;
      wr_d2    <= 1'b0;
      chk_rd_q <= 1'b0;
      exp_rd_q <= '0;
    end else begin
      acc_d1  <= accept;
      acc_d2  <= acc_d1;
      addr_d1 <= haddr;
      addr_d2 <= addr_d1;
      wr_d1   <= hwrite;
      wr_d2   <= wr_d1;
      if (accept) begin
        started  <= 1'b1;
        chk_rd_q <= check_read;
        exp_rd_q <= exp_rdata;
      end
    end
  end

  // ----------------------------------------
  // APB slave models
  // ----------------------------------------

  // Slave memories start from the same fill pattern as the expected contents
  initial begin
    wait_rng = 32'h35cc;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      for (int w = 0; w < 64; w++) begin
        slave_mem[i][w] = fill_word(WIN_BASE[i] + 32'(w * 4));
      end
    end
  end

  always @(negedge hclk10) begin
    wait_rng <= xorshift(wait_rng);
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (!psel[i]) begin
        // Junk the bridge has to mask
        pready[i] <= 1'b1;
        prdata[i] <= '1;
      end else if (!penable) begin
        wait_cnt[i] <= wait_rng[2*i +: 2];
        pready[i]   <= 1'b0;
      end else if (wait_cnt[i] != 2'd0) begin
        wait_cnt[i] <= wait_cnt[i] - 2'd1;
      end else begin
        pready[i] <= 1'b1;
        prdata[i] <= slave_mem[i][paddr[7:2]];
        if (pwrite) begin
          slave_mem[i][paddr[7:2]] <= pwdata;
        end
      end
    end
  end

  // ----------------------------------------
  // AHB driver
  // ----------------------------------------

  initial begin
    logic [31:0] rng;
    logic [31:0] word_off;
    logic [2:0]  target;
    int          cycles;
    hreset_n10 = 1'b0;
    hsel       = 1'b0;
    haddr      = '0;
    htrans     = 2'b00;
    hwrite     = 1'b0;
    hwdata     = '0;
    check_read = 1'b0;
    exp_rdata  = '0;
    rng        = 32'h35cc;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      for (int w = 0; w < 64; w++) begin
        ref_mem[i][w] = fill_word(WIN_BASE[i] + 32'(w * 4));
      end
    end
    repeat (3) @(posedge hclk10);
    @(negedge hclk10);
    hreset_n10 = 1'b1;
    for (int n = 0; n < NUM_XFERS; n++) begin
      rng      = xorshift(rng);
      target   = 3'(rng % 32'd5);
      word_off = {27'd0, rng[10:8], 2'b00};
      // Target 4 is the gap just above a window
      if (target == 3'd4) begin
        haddr = WIN_LAST[rng[13:12]] + 32'h1 + word_off;
      end else begin
        haddr = WIN_BASE[target[1:0]] + word_off;
      end
      hwrite = rng[16];
      // Now and then a cycle with hsel low, IDLE or BUSY
      if (rng[20:18] == 3'd0) begin
        hsel   = rng[21];
        htrans = rng[21] ? {1'b0, rng[22]} : ahb_pkg::HTRANS_NONSEQ;
        @(negedge hclk10);
      end
      check_read = !hwrite;
      exp_rdata  = (target == 3'd4) ? '0 : ref_mem[target[1:0]][word_off[7:2]];
      htrans     = rng[17] ? ahb_pkg::HTRANS_SEQ : ahb_pkg::HTRANS_NONSEQ;
      hsel       = 1'b1;
      rng        = xorshift(rng);
      if (hwrite && target != 3'd4) begin
        ref_mem[target[1:0]][word_off[7:2]] = rng;
      end
      @(negedge hclk10);
      hsel   = 1'b0;
      htrans = 2'b00;
      hwdata = rng;
      cycles = 0;
      while (!hready) begin
        if (cycles == XFER_TIMEOUT) begin
          abort_run("Timeout: hready stayed low, the transfer never completed");
        end else begin
          cycles++;
          @(negedge hclk10);
        end
      end
    end
    $display("test passed");
    $finish;
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  a_reset_state: assert property (@(posedge hclk10) disable iff (!hreset_n10)
      !started |-> hready && psel == '0 && !penable && hrdata == '0)
    else abort_run($sformatf(
      "** Error: hready = 0x%h psel = 0x%h penable = 0x%h hrdata = 0x%h, expected 0x1 0x0 0x0 0x0",
      $sampled(hready), $sampled(psel), $sampled(penable), $sampled(hrdata)));

  a_setup_psel: assert property (@(posedge hclk10) disable iff (!hreset_n10)
      acc_d2 |-> psel == window_sel(addr_d2))
    else abort_run($sformatf("** Error: psel = 0x%h, expected 0x%h",
      $sampled(psel), window_sel($sampled(addr_d2))));

  a_setup_bus: assert property (@(posedge hclk10) disable iff (!hreset_n10)
      acc_d2 |-> paddr == addr_d2 && pwrite == wr_d2 && !penable)
    else abort_run($sformatf(
      "** Error: paddr = 0x%h pwrite = 0x%h penable = 0x%h, expected 0x%h 0x%h 0x0",
      $sampled(paddr), $sampled(pwrite), $sampled(penable), $sampled(addr_d2),
      $sampled(wr_d2)));

  a_access_penable: assert property (@(posedge hclk10) disable iff (!hreset_n10)
      acc_d2 |=> penable)
    else abort_run($sformatf("** Error: penable = 0x%h, expected 0x1", $sampled(penable)));

  a_one_psel: assert property (@(posedge hclk10) disable iff (!hreset_n10)
      $onehot0(psel))
    else abort_run($sformatf("** Error: psel = 0x%h, more than one bit high", $sampled(psel)));

  // Wait state holds the whole APB request
  a_wait_hold: assert property (@(posedge hclk10) disable iff (!hreset_n10)
      stall |=> !hready && $stable(paddr) && $stable(pwrite) && $stable(pwdata))
    else abort_run("APB request changed or hready rose during a wait state");

  a_read_data: assert property (@(posedge hclk10) disable iff (!hreset_n10)
      $rose(hready) && chk_rd_q |-> hrdata == exp_rd_q)
    else abort_run($sformatf("** Error: hrdata = 0x%h, expected 0x%h",
      $sampled(hrdata), $sampled(exp_rd_q)));

  a_no_start: assert property (@(posedge hclk10) disable iff (!hreset_n10)
      hready && !accept |=> hready)
    else abort_run($sformatf(
      "** Error: hready = 0x%h, expected 0x1 with no valid transfer offered",
      $sampled(hready)));

  a_psel_rise: assert property (@(posedge hclk10) disable iff (!hreset_n10)
      $rose(psel_any) |-> acc_d2)
    else abort_run("psel rose without an accepted address phase two cycles earlier");

endmodule : tb_ahb2apb

`default_nettype wire

// ==== verilog/ahb2apb_bridge.sv ====
// AHB to APB bridge; parent must set NUM_SLAVES up to 16 and a non-overlapping address map
`timescale 1ns/1ps
`default_nettype none

module ahb2apb_bridge #(
  parameter int                  NUM_SLAVES = 4,
  parameter apb_pkg::slave_map_t SLAVE_BASE = '0,
  parameter apb_pkg::slave_map_t SLAVE_LAST = '0
) (
  // AHB side
  input  wire logic                          hclk10,
  input  wire logic                          hreset_n10,
  input  wire logic                          hsel,
  input  ahb_pkg::addr_t                     haddr,
  input  ahb_pkg::htrans_t                   htrans,
  input  ahb_pkg::data_t                     hwdata,
  input  wire logic                          hwrite,
  output ahb_pkg::data_t                     hrdata,
  output logic                               hready,

  // APB side, shared by all slaves
  output ahb_pkg::addr_t                     paddr,
  output logic                               penable,
  output logic                               pwrite,
  output ahb_pkg::data_t                     pwdata,

  // APB side, one entry per slave
  output logic [NUM_SLAVES-1:0]              psel,
  input  wire logic [NUM_SLAVES-1:0]         pready,
  input  ahb_pkg::data_t [NUM_SLAVES-1:0]    prdata
);

  logic           trans_valid;
  logic           data_phase;
  ahb_pkg::addr_t haddr_q;
  logic           hwrite_q;
  logic           xfer_done;

  apb_slot_if #(.NUM_SLAVES(NUM_SLAVES)) slot_bus ();

  // ----------------------------------------
  // AHB front end
  // ----------------------------------------

  ahb_front_end front_end_i (
    .hclk10      (hclk10),
    .hreset_n10  (hreset_n10),
    .hsel        (hsel),
    .haddr       (haddr),
    .htrans      (htrans),
    .hwrite      (hwrite),
    .xfer_done   (xfer_done),
    .trans_valid (trans_valid),
    .data_phase  (data_phase),
    .haddr_q     (haddr_q),
    .hwrite_q    (hwrite_q),
    .hready      (hready)
  );

  // ----------------------------------------
  // Slot array
  // ----------------------------------------

  for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_slot
    apb_slot #(
      .BASE (SLAVE_BASE[i]),
      .LAST (SLAVE_LAST[i]),
      .IDX  (i)
    ) slot_i (
      .hclk10      (hclk10),
      .hreset_n10  (hreset_n10),
      .haddr       (haddr),
      .trans_valid (trans_valid),
      .pready      (pready[i]),
      .prdata      (prdata[i]),
      .bus         (slot_bus.slot)
    );
  end

  // ----------------------------------------
  // APB sequencer
  // ----------------------------------------

  apb_sequencer #(
    .NUM_SLAVES (NUM_SLAVES)
  ) sequencer_i (
    .hclk10     (hclk10),
    .hreset_n10 (hreset_n10),
    .data_phase (data_phase),
    .haddr_q    (haddr_q),
    .hwrite_q   (hwrite_q),
    .bus        (slot_bus.sequencer),
    .paddr      (paddr),
    .pwrite     (pwrite),
    .penable    (penable),
    .hrdata     (hrdata),
    .xfer_done  (xfer_done)
  );

  assign psel = slot_bus.psel;

  // Write data is valid for the whole data phase
  assign pwdata = hwdata;

endmodule : ahb2apb_bridge

`default_nettype wire

// ==== verilog/ahb_front_end.sv ====
// AHB slave front end; single transfers only, no split or retry, hresp is always OKAY and not driven
`timescale 1ns/1ps
`default_nettype none

module ahb_front_end (
  input  wire logic           hclk10,
  input  wire logic           hreset_n10,
  input  wire logic           hsel,
  input  ahb_pkg::addr_t      haddr,
  input  ahb_pkg::htrans_t    htrans,
  input  wire logic           hwrite,
  input  wire logic           xfer_done,
  output logic                trans_valid,
  output logic                data_phase,
  output ahb_pkg::addr_t      haddr_q,
  output logic                hwrite_q,
  output logic                hready
);

  // High while the bridge can accept a new address
  logic addr_phase_q;
  logic start_code;

  // ----------------------------------------
  // Transfer qualification
  // ----------------------------------------

  // IDLE and BUSY are ignored
  assign start_code = (htrans == ahb_pkg::HTRANS_NONSEQ) ||
                      (htrans == ahb_pkg::HTRANS_SEQ);

  // Only sampled while no transfer is outstanding
  assign trans_valid = hsel && start_code && addr_phase_q;

  // ----------------------------------------
  // Phase tracking
  // ----------------------------------------

  always_ff @(posedge hclk10 or negedge hreset_n10) begin
    if (!hreset_n10) begin
      addr_phase_q <= 1'b1;
    end else if (trans_valid) begin
      addr_phase_q <= 1'b0;
    end else if (xfer_done) begin
      // APB side finished, reopen the address phase
      addr_phase_q <= 1'b1;
    end
  end

  // Address and direction of the accepted transfer
  always_ff @(posedge hclk10) begin
    if (trans_valid) begin
      haddr_q  <= haddr;
      hwrite_q <= hwrite;
    end
  end

  assign data_phase = ~addr_phase_q;

  // Wait states last for the whole data phase
  assign hready = addr_phase_q;

endmodule : ahb_front_end

`default_nettype wire

// ==== verilog/ahb_pkg.sv ====
// AHB-side widths and transfer codes; 32-bit address and data only, no burst or size support
`default_nettype none

package ahb_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------

  // Byte address, shared by the AHB and APB sides
  typedef logic [31:0] addr_t;

  // One data word
  typedef logic [31:0] data_t;

  // ----------------------------------------
  // Transfer type
  // ----------------------------------------

  typedef logic [1:0] htrans_t;

  // Only these two start a transfer
  localparam htrans_t HTRANS_NONSEQ = 2'b10;
  localparam htrans_t HTRANS_SEQ    = 2'b11;

endpackage : ahb_pkg

`default_nettype wire

// ==== verilog/apb_pkg.sv ====
// APB-side state and address-map types; at most MAX_SLAVES windows, each an inclusive range
`default_nettype none

package apb_pkg;

  // ----------------------------------------
  // Sequencer state
  // ----------------------------------------

  // One-hot, one bit per APB phase
  typedef enum logic [2:0] {
    APB_IDLE   = 3'b001,
    APB_SETUP  = 3'b010,
    APB_ACCESS = 3'b100
  } apb_state_t;

  // ----------------------------------------
  // Address map
  // ----------------------------------------

  // Upper bound on generated slots
  localparam int MAX_SLAVES = 16;

  // One address per slot
  // Used both for window bases and for window last addresses
  typedef ahb_pkg::addr_t [MAX_SLAVES-1:0] slave_map_t;

endpackage : apb_pkg

`default_nettype wire

// ==== verilog/apb_sequencer.sv ====
// APB master FSM; one transfer at a time, every transfer returns to IDLE, no pslverr support
`timescale 1ns/1ps
`default_nettype none

module apb_sequencer #(
  parameter int NUM_SLAVES = 4
) (
  input  wire logic        hclk10,
  input  wire logic        hreset_n10,
  input  wire logic        data_phase,
  input  ahb_pkg::addr_t   haddr_q,
  input  wire logic        hwrite_q,
  apb_slot_if.sequencer    bus,
  output ahb_pkg::addr_t   paddr,
  output logic             pwrite,
  output logic             penable,
  output ahb_pkg::data_t   hrdata,
  output logic             xfer_done
);

  apb_pkg::apb_state_t state_q;

  logic           pready_any;
  logic           psel_any;
  ahb_pkg::data_t prdata_any;
  logic           access_end;

  // ----------------------------------------
  // Response merge
  // ----------------------------------------

  // Slots gate their own responses, so a plain OR is enough
  assign pready_any = |bus.pready_hit;
  assign psel_any   = |bus.psel;

  always_comb begin
    prdata_any = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      prdata_any = prdata_any | bus.prdata_hit[i];
    end
  end

  // Unmapped address has no psel and ends ACCESS right away
  assign access_end = (state_q == apb_pkg::APB_ACCESS) && (pready_any || !psel_any);

  // ----------------------------------------
  // Strobes to slots and front end
  // ----------------------------------------

  // Slots load psel on the edge that enters SETUP
  assign bus.load_sel  = (state_q == apb_pkg::APB_IDLE) && data_phase;
  assign bus.clear_sel = access_end;
  assign xfer_done     = access_end;

  assign penable = (state_q == apb_pkg::APB_ACCESS);

  // ----------------------------------------
  // State machine
  // ----------------------------------------

  always_ff @(posedge hclk10 or negedge hreset_n10) begin
    if (!hreset_n10) begin
      state_q <= apb_pkg::APB_IDLE;
      paddr   <= '0;
      pwrite  <= 1'b0;
      hrdata  <= '0;
    end else begin
      case (state_q)
        apb_pkg::APB_IDLE: begin
          if (data_phase) begin
            state_q <= apb_pkg::APB_SETUP;
            paddr   <= haddr_q;
            pwrite  <= hwrite_q;
          end
        end
        apb_pkg::APB_SETUP: begin
          state_q <= apb_pkg::APB_ACCESS;
        end
        apb_pkg::APB_ACCESS: begin
          // paddr and pwrite hold through wait states
          if (access_end) begin
            state_q <= apb_pkg::APB_IDLE;
            hrdata  <= prdata_any;
          end
        end
        default: begin
          state_q <= apb_pkg::APB_IDLE;
        end
      endcase
    end
  end

endmodule : apb_sequencer

`default_nettype wire

// ==== verilog/apb_slot.sv ====
// One APB slave slot; window is BASE to LAST inclusive, IDX must be unique and below NUM_SLAVES
`timescale 1ns/1ps
`default_nettype none

module apb_slot #(
  parameter ahb_pkg::addr_t BASE = '0,
  parameter ahb_pkg::addr_t LAST = '0,
  parameter int             IDX  = 0
) (
  input  wire logic        hclk10,
  input  wire logic        hreset_n10,
  input  ahb_pkg::addr_t   haddr,
  input  wire logic        trans_valid,
  input  wire logic        pready,
  input  ahb_pkg::data_t   prdata,
  apb_slot_if.slot         bus
);

  logic in_window;
  logic hit_q;
  logic psel_q;

  // ----------------------------------------
  // Window decode
  // ----------------------------------------

  assign in_window = (haddr >= BASE) && (haddr <= LAST);

  // Hit of the address sampled with the transfer
  always_ff @(posedge hclk10 or negedge hreset_n10) begin
    if (!hreset_n10) begin
      hit_q <= 1'b0;
    end else if (trans_valid) begin
      hit_q <= in_window;
    end
  end

  // ----------------------------------------
  // Select
  // ----------------------------------------

  always_ff @(posedge hclk10 or negedge hreset_n10) begin
    if (!hreset_n10) begin
      psel_q <= 1'b0;
    end else if (bus.clear_sel) begin
      psel_q <= 1'b0;
    end else if (bus.load_sel) begin
      psel_q <= hit_q;
    end
  end

  assign bus.psel[IDX] = psel_q;

  // Unselected slots contribute nothing to the OR merge
  assign bus.pready_hit[IDX] = psel_q & pready;
  assign bus.prdata_hit[IDX] = psel_q ? prdata : '0;

endmodule : apb_slot

`default_nettype wire

// ==== verilog/apb_slot_if.sv ====
// Sequencer to slot-array link; one bit or word per slot, each slot drives only its own entry
`timescale 1ns/1ps
`default_nettype none

interface apb_slot_if #(
  parameter int NUM_SLAVES = 4
) ();

  // ----------------------------------------
  // Sequencer to slots
  // ----------------------------------------

  // Copy registered hit into psel
  logic load_sel;

  // Drop every psel at the end of ACCESS
  logic clear_sel;

  // ----------------------------------------
  // Slots to sequencer
  // ----------------------------------------

  logic [NUM_SLAVES-1:0] psel;

  // Responses already masked by the slot's own psel
  logic [NUM_SLAVES-1:0] pready_hit;
  ahb_pkg::data_t [NUM_SLAVES-1:0] prdata_hit;

  modport sequencer (
    output load_sel,
    output clear_sel,
    input  psel,
    input  pready_hit,
    input  prdata_hit
  );

  modport slot (
    input  load_sel,
    input  clear_sel,
    output psel,
    output pready_hit,
    output prdata_hit
  );

endinterface : apb_slot_if

`default_nettype wire
